//--- tb.f
serviceProtocolPkg.sv
spApbRegs.sv
spEncoder.sv
spPacketOut.sv
spTop.sv
spTb_assert.sv
spTb.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= spTb
FLIST ?= tb.f
BUILD ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -Wno-fatal
RUNFLAGS ?= +verilator+error+limit+1000

SRCS := $(shell grep -v '^+' $(FLIST))
BIN := $(BUILD)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FLIST)

run: $(BIN)
	./$(BIN) $(RUNFLAGS) > $(LOG) 2>&1; cat $(LOG)
	grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

//--- spTb.sv
`timescale 1ns/1ps

module spTb import serviceProtocolPkg::*; ();

	typedef struct packed {
		logic [addrWidth-1:0] addr;
		logic [wordWidth-1:0] size;
		TCommandCode cmd;
		logic [7:0] abortAfter; // 0 runs the packet to the end.
		logic backPressure;
		logic lateFill; // payload written only after enable.
	} TRow;

	localparam int rowCount = 5;

	logic clk;
	logic rst;
	logic [apbAddrWidth-1:0] paddr;
	logic psel;
	logic penable;
	logic pwrite;
	logic [apbDataWidth-1:0] pwdata;
	logic [apbDataWidth-1:0] prdata;
	logic pready;
	logic pslverr;
	logic [wordWidth-1:0] outData;
	logic outValid;
	logic outReady;

	TRow rows [rowCount];
	int errors = 0;
	logic [31:0] rngState = 32'h1905_357b;
	logic [wordWidth-1:0] fifoModel [$]; // words the DUT FIFO should hold.
	logic [wordWidth-1:0] freshWords [$];
	logic [wordWidth-1:0] expected [$];
	logic [wordWidth-1:0] packetCount = '0;

	spTop spTop_inst (
		.clk(clk), .rst(rst),
		.paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite), .pwdata(pwdata),
		.prdata(prdata), .pready(pready), .pslverr(pslverr),
		.outData(outData), .outValid(outValid), .outReady(outReady)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	function automatic logic [31:0] lcgNext(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
			errors++;
		end
	endtask

	// setup phase, then access phase; the transfer completes on the third edge.
	task automatic apbAccess(input logic [7:0] addr, input logic write, input logic [31:0] data,
			output logic [31:0] rdata, output logic err);
		@(posedge clk);
		paddr <= addr;
		pwrite <= write;
		pwdata <= data;
		psel <= 1'b1;
		penable <= 1'b0;
		@(posedge clk);
		penable <= 1'b1;
		@(posedge clk);
		rdata = prdata;
		err = pslverr;
		psel <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic apbWrite(input logic [7:0] addr, input logic [31:0] data, input logic expErr);
		logic [31:0] rdata;
		logic err;
		apbAccess(addr, 1'b1, data, rdata, err);
		checkValue("pslverr", 32'(err), 32'(expErr));
	endtask

	task automatic apbRead(input logic [7:0] addr, input logic expErr, output logic [31:0] rdata);
		logic err;
		apbAccess(addr, 1'b0, 32'h0, rdata, err);
		checkValue("pslverr", 32'(err), 32'(expErr));
	endtask

	task automatic writeFresh();
		foreach (freshWords[i])
			apbWrite(regData, 32'(freshWords[i]), 1'b0);
	endtask

	// the sink stops accepting once count words have arrived.
	task automatic collectWords(input int count, input logic backPressure);
		int got;
		got = 0;
		while (got < count) begin
			@(posedge clk);
			if (outValid && outReady) begin
				checkValue("outData", 32'(outData), 32'(expected.pop_front()));
				got++;
			end
			rngState = lcgNext(rngState);
			if (got == count)
				outReady <= 1'b0;
			else if (backPressure)
				outReady <= (rngState[17:16] != 2'b00); // low about a quarter of the time.
			else
				outReady <= 1'b1;
		end
	endtask

	initial begin
		repeat (8 + 200 * rowCount) @(posedge clk);
		$display("timeout: the packet sequence did not finish within the cycle budget");
		$display("Simulation FAILED");
		$finish;
	end

	initial begin
		TRow row;
		logic [31:0] status;
		logic [wordWidth-1:0] sum;
		int newWords;
		int take;
		rows[0] = '{8'h3A, 16'd1, CMD_READ, 8'd0, 1'b0, 1'b0};
		rows[1] = '{8'hC5, 16'd3, CMD_WRITE, 8'd0, 1'b1, 1'b0};
		rows[2] = '{8'h11, 16'd8, CMD_STATUS, 8'd4, 1'b1, 1'b0};
		rows[3] = '{8'h7E, 16'd8, CMD_RESET, 8'd0, 1'b1, 1'b0};
		rows[4] = '{8'h42, 16'd3, CMD_WRITE, 8'd0, 1'b0, 1'b1};
		rst <= 1'b1;
		paddr <= '0;
		psel <= 1'b0;
		penable <= 1'b0;
		pwrite <= 1'b0;
		pwdata <= '0;
		outReady <= 1'b0;
		repeat (8) @(posedge clk);
		rst <= 1'b0;

		apbRead(8'h18, 1'b1, status); // unmapped offset.
		apbWrite(regStatus, 32'h0, 1'b1);
		apbRead(regStatus, 1'b0, status);
		checkValue("fifoEmpty", 32'(status[1]), 32'h1);

		for (int r = 0; r < rowCount; r++) begin
			row = rows[r];
			apbWrite(regAddr, 32'(row.addr), 1'b0);
			apbWrite(regSize, 32'(row.size), 1'b0);
			apbWrite(regCmd, 32'(row.cmd), 1'b0);
			newWords = int'(row.size) - fifoModel.size();
			freshWords.delete();
			for (int i = 0; i < newWords; i++) begin
				rngState = lcgNext(rngState);
				freshWords.push_back(rngState[31:16]);
				fifoModel.push_back(rngState[31:16]);
			end
			packetCount = packetCount + 16'd1;
			expected.delete();
			expected.push_back({row.addr, row.size[15:8]});
			expected.push_back({row.size[7:0], 8'(row.cmd)});
			sum = expected[0] + expected[1];
			for (int i = 0; i < int'(row.size); i++) begin
				expected.push_back(fifoModel[i]);
				sum = sum + fifoModel[i];
			end
			expected.push_back(sum);
			expected.push_back(packetCount);
			if (!row.lateFill) begin
				writeFresh();
				apbRead(regStatus, 1'b0, status);
				checkValue("fillCount", 32'(status[15:8]), 32'(fifoModel.size()));
			end
			apbWrite(regCtrl, 32'h1, 1'b0);
			take = (row.abortAfter != 0) ? int'(row.abortAfter) : int'(row.size) + 4;
			fork
				collectWords(take, row.backPressure);
				if (row.lateFill) begin
					repeat (20) @(posedge clk);
					apbRead(regStatus, 1'b0, status);
					checkValue("fifoEmpty", 32'(status[1]), 32'h1);
					writeFresh();
				end
			join
			if (row.abortAfter == 0) begin
				apbRead(regStatus, 1'b0, status);
				checkValue("packetDone", 32'(status[0]), 32'h1);
				repeat (int'(row.size)) void'(fifoModel.pop_front());
			end
			apbWrite(regCtrl, 32'h0, 1'b0);
			if (row.abortAfter != 0) begin
				repeat (2) @(posedge clk);
				checkValue("outValid", 32'(outValid), 32'h0);
				// one payload word more was popped than reached the stream.
				repeat (int'(row.abortAfter) - 1) void'(fifoModel.pop_front());
				apbRead(regStatus, 1'b0, status);
				checkValue("fillCount", 32'(status[15:8]), 32'(fifoModel.size()));
			end
		end

		errors += spTop_inst.spTb_assert_inst.failCount;
		$display("run finished with %0d errors", errors);
		if (errors == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

//--- spTb_assert.sv
`timescale 1ns/1ps

module spTb_assert import serviceProtocolPkg::*; (
	input logic clk,
	input logic rst,
	input logic [wordWidth-1:0] outData,
	input logic outValid,
	input logic outReady,
	input logic pready
);

	int failCount = 0;

	// held word may not change while the sink stalls.
	outDataHeld: assert property (@(posedge clk) disable iff (rst)
		outValid && !outReady |=> $stable(outData))
	else begin
		$error("outData changed while outValid was high and outReady low");
		failCount++;
	end

	validAfterReset: assert property (@(posedge clk) rst |=> !outValid)
	else begin
		$error("outValid high in the cycle after reset");
		failCount++;
	end

	noWaitStates: assert property (@(posedge clk) pready)
	else begin
		$error("pready went low");
		failCount++;
	end

endmodule

bind spTop spTb_assert spTb_assert_inst (
	.clk(clk), .rst(rst), .outData(outData), .outValid(outValid),
	.outReady(outReady), .pready(pready)
);

//--- spTop.sv
`timescale 1ns/1ps

module spTop import serviceProtocolPkg::*; (
	input logic clk,
	input logic rst,
	input logic [apbAddrWidth-1:0] paddr,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [apbDataWidth-1:0] pwdata,
	output logic [apbDataWidth-1:0] prdata,
	output logic pready,
	output logic pslverr,
	output logic [wordWidth-1:0] outData,
	output logic outValid,
	input logic outReady
);

	logic [addrWidth-1:0] dstAddr;
	logic [wordWidth-1:0] payloadSize;
	TCommandCode cmdCode;
	logic enable;
	logic popRequest;
	logic [wordWidth-1:0] popData;
	logic popDone;
	logic pushRequest;
	logic [wordWidth-1:0] pushData;
	logic pushDone;
	logic packetDone;

	spApbRegs spApbRegs_inst (
		.clk(clk), .rst(rst),
		.paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite), .pwdata(pwdata),
		.prdata(prdata), .pready(pready), .pslverr(pslverr),
		.dstAddr(dstAddr), .payloadSize(payloadSize), .cmdCode(cmdCode), .enable(enable),
		.popRequest(popRequest), .popData(popData), .popDone(popDone),
		.packetDone(packetDone)
	);

	spEncoder spEncoder_inst (
		.clk(clk), .rst(rst),
		.dstAddr(dstAddr), .payloadSize(payloadSize), .cmdCode(cmdCode), .enable(enable),
		.popRequest(popRequest), .popData(popData), .popDone(popDone),
		.pushRequest(pushRequest), .pushData(pushData), .pushDone(pushDone),
		.packetDone(packetDone)
	);

	spPacketOut spPacketOut_inst (
		.clk(clk), .rst(rst), .enable(enable),
		.pushRequest(pushRequest), .pushData(pushData), .pushDone(pushDone),
		.outData(outData), .outValid(outValid), .outReady(outReady)
	);

endmodule

//--- spPacketOut.sv
`timescale 1ns/1ps

module spPacketOut import serviceProtocolPkg::*; (
	input logic clk,
	input logic rst,
	input logic enable,
	input logic pushRequest,
	input logic [wordWidth-1:0] pushData,
	output logic pushDone,
	output logic [wordWidth-1:0] outData,
	output logic outValid,
	input logic outReady
);

	logic transfer;

	assign transfer = outValid && outReady;
	assign pushDone = transfer;

	always_ff @(posedge clk) begin
		if (rst) begin
			outValid <= 1'b0;
		end else if (!enable) begin
			outValid <= 1'b0; // packet abandoned.
		end else if (pushRequest) begin
			outValid <= 1'b1;
		end else if (transfer) begin
			outValid <= 1'b0;
		end
	end

	// word is held until the next request.
	always_ff @(posedge clk) begin
		if (pushRequest)
			outData <= pushData;
	end

endmodule

//--- spEncoder.sv
`timescale 1ns/1ps

module spEncoder import serviceProtocolPkg::*; (
	input logic clk,
	input logic rst,
	input logic [addrWidth-1:0] dstAddr,
	input logic [wordWidth-1:0] payloadSize,
	input TCommandCode cmdCode,
	input logic enable,
	output logic popRequest,
	input logic [wordWidth-1:0] popData,
	input logic popDone,
	output logic pushRequest,
	output logic [wordWidth-1:0] pushData,
	input logic pushDone,
	output logic packetDone
);

	TEncState state;
	TEncState nextState;

	logic [wordWidth-1:0] head1;
	logic [wordWidth-1:0] head2;
	logic [wordWidth-1:0] wordCount;
	logic [wordWidth-1:0] checksum;
	logic [wordWidth-1:0] packetNum;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= WAIT;
			packetNum <= '0;
		end else begin
			state <= nextState;
			if (state == HEAD1_L)
				packetNum <= packetNum + 1'b1; // counts started packets.
		end
	end

	always_ff @(posedge clk) begin
		if (state == WAIT && enable) begin
			head1 <= {dstAddr, payloadSize[15:8]};
			head2 <= {payloadSize[7:0], cmdCode};
			wordCount <= payloadSize;
			checksum <= '0;
		end
		if (state == DATA_LR)
			wordCount <= wordCount - 1'b1;
		// header and payload words go into the sum.
		if (state == HEAD1_L || state == HEAD2_L || state == DATA_SR)
			checksum <= checksum + pushData;
	end

	always_comb begin
		popRequest = (state == DATA_LR);
		pushRequest = 1'b0;
		pushData = '0;
		packetDone = (state == FINISHED);
		case (state)
			HEAD1_L: begin
				pushRequest = 1'b1;
				pushData = head1;
			end
			HEAD1_W: pushData = head1;
			HEAD2_L: begin
				pushRequest = 1'b1;
				pushData = head2;
			end
			HEAD2_W: pushData = head2;
			DATA_LR, DATA_LW, DATA_SW: pushData = popData;
			DATA_SR: begin
				pushRequest = 1'b1;
				pushData = popData;
			end
			SUM_L: begin
				pushRequest = 1'b1;
				pushData = checksum;
			end
			SUM_W: pushData = checksum;
			NUM_L: begin
				pushRequest = 1'b1;
				pushData = packetNum;
			end
			NUM_W: pushData = packetNum;
			default: pushData = '0;
		endcase
	end

	always_comb begin
		nextState = state;
		if (!enable) begin
			nextState = WAIT;
		end else begin
			case (state)
				WAIT: nextState = HEAD1_L;
				HEAD1_L: nextState = HEAD1_W;
				HEAD1_W: if (pushDone) nextState = HEAD2_L;
				HEAD2_L: nextState = HEAD2_W;
				HEAD2_W: if (pushDone) nextState = DATA_LR;
				DATA_LR: nextState = DATA_LW;
				DATA_LW: if (popDone) nextState = DATA_SR;
				DATA_SR: nextState = DATA_SW;
				DATA_SW: begin
					// counter was already stepped in DATA_LR.
					if (pushDone)
						nextState = (wordCount == '0) ? SUM_L : DATA_LR;
				end
				SUM_L: nextState = SUM_W;
				SUM_W: if (pushDone) nextState = NUM_L;
				NUM_L: nextState = NUM_W;
				NUM_W: if (pushDone) nextState = FINISHED;
				FINISHED: nextState = FINISHED; // until enable is cleared.
				default: nextState = WAIT;
			endcase
		end
	end

endmodule

//--- spApbRegs.sv
`timescale 1ns/1ps

module spApbRegs import serviceProtocolPkg::*; (
	input logic clk,
	input logic rst,
	input logic [apbAddrWidth-1:0] paddr,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [apbDataWidth-1:0] pwdata,
	output logic [apbDataWidth-1:0] prdata,
	output logic pready,
	output logic pslverr,
	output logic [addrWidth-1:0] dstAddr,
	output logic [wordWidth-1:0] payloadSize,
	output TCommandCode cmdCode,
	output logic enable,
	input logic popRequest,
	output logic [wordWidth-1:0] popData,
	output logic popDone,
	input logic packetDone
);

	logic [wordWidth-1:0] fifoMem [fifoDepth];
	logic [fifoPtrWidth-1:0] wrPtr;
	logic [fifoPtrWidth-1:0] rdPtr;
	logic [fifoPtrWidth:0] fillCount;
	logic fifoEmpty;
	logic fifoFull;
	logic access;
	logic writeAccess;
	logic mapped;
	logic pushWord;
	logic popWord;
	logic popPending;
	logic [apbDataWidth-1:0] statusWord;

	assign access = psel && penable;
	assign writeAccess = access && pwrite;

	assign fifoEmpty = (fillCount == '0);
	assign fifoFull = (fillCount == (fifoPtrWidth + 1)'(fifoDepth));

	assign pushWord = writeAccess && (paddr == regData) && !fifoFull;
	// a pop waits here while the FIFO is empty.
	assign popWord = (popRequest || popPending) && !fifoEmpty && enable;

	always_comb begin
		case (paddr)
			regCtrl, regAddr, regSize, regCmd, regData, regStatus: mapped = 1'b1;
			default: mapped = 1'b0;
		endcase
	end

	assign pready = 1'b1; // no wait states.
	assign pslverr = access && (!mapped || (pwrite && (paddr == regStatus)) ||
		(pwrite && (paddr == regData) && fifoFull));

	always_comb begin
		statusWord = '0;
		statusWord[0] = packetDone;
		statusWord[1] = fifoEmpty;
		statusWord[2] = fifoFull;
		statusWord[15:8] = 8'(fillCount);
	end

	always_comb begin
		prdata = '0;
		case (paddr)
			regCtrl: prdata[ctrlEnableBit] = enable;
			regAddr: prdata[addrWidth-1:0] = dstAddr;
			regSize: prdata[wordWidth-1:0] = payloadSize;
			regCmd: prdata[7:0] = cmdCode;
			regStatus: prdata = statusWord;
			default: prdata = '0; // data port reads as zero.
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			enable <= 1'b0;
			dstAddr <= '0;
			payloadSize <= '0;
			cmdCode <= CMD_READ;
		end else if (writeAccess) begin
			case (paddr)
				regCtrl: enable <= pwdata[ctrlEnableBit];
				regAddr: dstAddr <= pwdata[addrWidth-1:0];
				regSize: payloadSize <= pwdata[wordWidth-1:0];
				regCmd: cmdCode <= TCommandCode'(pwdata[7:0]);
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (pushWord)
			fifoMem[wrPtr] <= pwdata[wordWidth-1:0];
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wrPtr <= '0;
			rdPtr <= '0;
			fillCount <= '0;
		end else begin
			if (pushWord)
				wrPtr <= wrPtr + 1'b1; // wraps at the depth.
			if (popWord)
				rdPtr <= rdPtr + 1'b1;
			case ({pushWord, popWord})
				2'b10: fillCount <= fillCount + 1'b1;
				2'b01: fillCount <= fillCount - 1'b1;
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			popPending <= 1'b0;
			popDone <= 1'b0;
		end else begin
			popDone <= popWord;
			if (!enable || popWord)
				popPending <= 1'b0; // an abort drops the waiting pop.
			else if (popRequest)
				popPending <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (popWord)
			popData <= fifoMem[rdPtr];
	end

endmodule

//--- serviceProtocolPkg.sv
package serviceProtocolPkg;

	localparam int wordWidth = 16;
	localparam int addrWidth = 8;
	localparam int apbAddrWidth = 8;
	localparam int apbDataWidth = 32;

	localparam int fifoDepth = 32;
	localparam int fifoPtrWidth = $clog2(fifoDepth); // 5 for 32 entries.

	// register map.
	localparam logic [apbAddrWidth-1:0] regCtrl = 8'h00;
	localparam logic [apbAddrWidth-1:0] regAddr = 8'h04;
	localparam logic [apbAddrWidth-1:0] regSize = 8'h08;
	localparam logic [apbAddrWidth-1:0] regCmd = 8'h0C;
	localparam logic [apbAddrWidth-1:0] regData = 8'h10;
	localparam logic [apbAddrWidth-1:0] regStatus = 8'h14;

	localparam int ctrlEnableBit = 0;

	typedef enum logic [7:0] {
		CMD_READ = 8'h01,
		CMD_WRITE = 8'h02,
		CMD_STATUS = 8'h03,
		CMD_RESET = 8'h04
	} TCommandCode;

	// load/wait pairs per packet word.
	typedef enum logic [3:0] {
		WAIT,
		HEAD1_L, HEAD1_W,
		HEAD2_L, HEAD2_W,
		DATA_LR, DATA_LW, DATA_SR, DATA_SW,
		SUM_L, SUM_W,
		NUM_L, NUM_W,
		FINISHED
	} TEncState;

endpackage
